//--- logic/tx_sample_pkg.sv
`default_nettype none

package tx_sample_pkg;

    localparam int SAMPLE_W = 18;

    // Word size of the whole shaping path.
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    typedef struct packed {
        sample_t i;
        sample_t q;
    } iq_sample_t;

    // Dibit codes in Gray order around the constellation.
    typedef enum logic [1:0] {
        q_pp = 2'b00,  // +I, +Q.
        q_mp = 2'b01,  // -I, +Q.
        q_mm = 2'b11,  // -I, -Q.
        q_pm = 2'b10   // +I, -Q.
    } quadrant_e;

endpackage

`default_nettype wire

//--- logic/srrc_coef_pkg.sv
`default_nettype none

package srrc_coef_pkg;

    localparam int NUM_TAPS   = 17;
    localparam int NUM_UNIQUE = 9;  // Taps 0..7 mirrored plus the center tap.

    // Full-width product of a pre-added sample and a coefficient.
    typedef logic signed [2*tx_sample_pkg::SAMPLE_W-1:0] product_t;

    // Square-root raised cosine, tap 0 out to the center tap.
    localparam tx_sample_pkg::sample_t COEF [NUM_UNIQUE] = '{
         18'sd314,
        -18'sd2115,
        -18'sd5743,
        -18'sd6936,
        -18'sd719,
         18'sd15367,
         18'sd37897,
         18'sd57966,
         18'sd66023
    };

    // Product bits that feed the adder tree.
    localparam int PROD_MSB = 34;
    localparam int PROD_LSB = 17;

endpackage

`default_nettype wire

//--- logic/tx_rate_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tx_rate_gen #(
    parameter int CLKS_PER_SAMPLE    = 4,
    parameter int SAMPLES_PER_SYMBOL = 4
) (
    input  logic clk,
    input  logic reset,
    output logic smp_stb,
    output logic sym_stb
);

    localparam int CLK_W = $clog2(CLKS_PER_SAMPLE);
    localparam int SMP_W = $clog2(SAMPLES_PER_SYMBOL);
    localparam logic [CLK_W-1:0] CLK_LAST = CLK_W'(CLKS_PER_SAMPLE - 1);
    localparam logic [SMP_W-1:0] SMP_LAST = SMP_W'(SAMPLES_PER_SYMBOL - 1);

    logic [CLK_W-1:0] clk_cnt;
    logic [SMP_W-1:0] smp_cnt;
    logic             clk_wrap;

    assign clk_wrap = (clk_cnt == CLK_LAST);

    always_ff @(posedge clk) begin
        if (reset || clk_wrap) begin
            clk_cnt <= '0;
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    // Counts sample strobes within one symbol.
    always_ff @(posedge clk) begin
        if (reset) begin
            smp_cnt <= '0;
        end else if (smp_stb) begin
            if (smp_cnt == SMP_LAST) begin
                smp_cnt <= '0;
            end else begin
                smp_cnt <= smp_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            smp_stb <= 1'b0;
            sym_stb <= 1'b0;
        end else begin
            smp_stb <= clk_wrap;
            sym_stb <= clk_wrap && (smp_cnt == '0);  // First sample of a symbol.
        end
    end

    a_sym_in_smp: assert property (@(posedge clk) disable iff (reset)
        sym_stb |-> smp_stb);

    a_smp_single: assert property (@(posedge clk) disable iff (reset)
        smp_stb |=> !smp_stb);

endmodule

`default_nettype wire

//--- logic/qpsk_mapper.sv
`timescale 1ns/1ps
`default_nettype none

module qpsk_mapper #(
    parameter int AMPLITUDE = 40000
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      smp_stb,
    input  logic                      sym_stb,
    input  logic [1:0]                dibit,
    output tx_sample_pkg::iq_sample_t impulse
);

    localparam tx_sample_pkg::sample_t AMP_POS = tx_sample_pkg::sample_t'(AMPLITUDE);
    localparam tx_sample_pkg::sample_t AMP_NEG = -AMP_POS;

    tx_sample_pkg::quadrant_e  quad;
    tx_sample_pkg::iq_sample_t mapped;

    assign quad = tx_sample_pkg::quadrant_e'(dibit);

    // Bit 0 flips I, bit 1 flips Q.
    always_comb begin
        mapped.i = AMP_POS;
        mapped.q = AMP_POS;
        case (quad)
            tx_sample_pkg::q_pp: begin
                mapped.i = AMP_POS;
                mapped.q = AMP_POS;
            end
            tx_sample_pkg::q_mp: begin
                mapped.i = AMP_NEG;
                mapped.q = AMP_POS;
            end
            tx_sample_pkg::q_mm: begin
                mapped.i = AMP_NEG;
                mapped.q = AMP_NEG;
            end
            tx_sample_pkg::q_pm: begin
                mapped.i = AMP_POS;
                mapped.q = AMP_NEG;
            end
            default: begin
                mapped.i = AMP_POS;
                mapped.q = AMP_POS;
            end
        endcase
    end

    // One symbol sample, then zeros until the next symbol.
    always_ff @(posedge clk) begin
        if (reset) begin
            impulse <= '0;
        end else if (smp_stb) begin
            if (sym_stb) begin
                impulse <= mapped;
            end else begin
                impulse <= '0;
            end
        end
    end

    a_impulse_on_strobe: assert property (@(posedge clk) disable iff (reset)
        !$stable(impulse) |-> $past(smp_stb));

endmodule

`default_nettype wire

//--- logic/srrc_tx_flt.sv
`timescale 1ns/1ps
`default_nettype none

module srrc_tx_flt (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   smp_stb,
    input  tx_sample_pkg::sample_t in,
    output tx_sample_pkg::sample_t out,
    output logic                   out_valid
);

    localparam int DEPTH  = srrc_coef_pkg::NUM_TAPS - 1;
    localparam int CENTER = srrc_coef_pkg::NUM_UNIQUE - 1;

    tx_sample_pkg::sample_t   hist      [1:DEPTH];
    tx_sample_pkg::sample_t   x         [0:DEPTH];
    tx_sample_pkg::sample_t   pre_sum   [0:CENTER];
    srrc_coef_pkg::product_t  prod      [0:CENTER];
    tx_sample_pkg::sample_t   prod_bits [0:CENTER];
    tx_sample_pkg::sample_t   lvl2      [0:4];
    tx_sample_pkg::sample_t   lvl3      [0:2];
    tx_sample_pkg::sample_t   lvl4      [0:1];
    tx_sample_pkg::sample_t   acc;

    // History of past samples, x1 is the newest.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 1; k <= DEPTH; k++) begin
                hist[k] <= '0;
            end
        end else if (smp_stb) begin
            hist[1] <= in;
            for (int k = 2; k <= DEPTH; k++) begin
                hist[k] <= hist[k-1];
            end
        end
    end

    always_comb begin
        x[0] = in;  // Present input is tap x0.
        for (int k = 1; k <= DEPTH; k++) begin
            x[k] = hist[k];
        end
    end

    // Symmetric taps share a coefficient, so add them first.
    always_comb begin
        for (int k = 0; k < CENTER; k++) begin
            pre_sum[k] = x[k] + x[DEPTH-k];  // Wraps at 18 bits.
        end
        pre_sum[CENTER] = x[CENTER];
    end

    always_comb begin
        for (int k = 0; k <= CENTER; k++) begin
            prod[k]      = pre_sum[k] * srrc_coef_pkg::COEF[k];
            prod_bits[k] = prod[k][srrc_coef_pkg::PROD_MSB:srrc_coef_pkg::PROD_LSB];
        end
    end

    // Adder tree, every level wraps at 18 bits.
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            lvl2[k] = prod_bits[2*k] + prod_bits[2*k+1];
        end
        lvl2[4] = prod_bits[8];

        for (int k = 0; k < 2; k++) begin
            lvl3[k] = lvl2[2*k] + lvl2[2*k+1];
        end
        lvl3[2] = lvl2[4];

        lvl4[0] = lvl3[0] + lvl3[2];
        lvl4[1] = lvl3[1];

        acc = lvl4[0] + lvl4[1];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out       <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= smp_stb;  // Flags the sample just registered.
            if (smp_stb) begin
                out <= acc;
            end
        end
    end

    a_valid_single: assert property (@(posedge clk) disable iff (reset)
        out_valid |=> !out_valid);

endmodule

`default_nettype wire

//--- logic/qpsk_tx_top.sv
`timescale 1ns/1ps
`default_nettype none

module qpsk_tx_top #(
    parameter int CLKS_PER_SAMPLE    = 4,
    parameter int SAMPLES_PER_SYMBOL = 4,
    parameter int AMPLITUDE          = 40000
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [1:0]                dibit,
    output logic                      sym_req,
    output tx_sample_pkg::iq_sample_t tx,
    output logic                      tx_valid
);

    logic                      smp_stb;
    tx_sample_pkg::iq_sample_t impulse;
    tx_sample_pkg::sample_t    tx_i;
    tx_sample_pkg::sample_t    tx_q;

    tx_rate_gen #(
        .CLKS_PER_SAMPLE    (CLKS_PER_SAMPLE),
        .SAMPLES_PER_SYMBOL (SAMPLES_PER_SYMBOL)
    ) rate_gen (
        .clk     (clk),
        .reset   (reset),
        .smp_stb (smp_stb),
        .sym_stb (sym_req)  // Symbol strobe doubles as the dibit request.
    );

    qpsk_mapper #(
        .AMPLITUDE (AMPLITUDE)
    ) mapper (
        .clk     (clk),
        .reset   (reset),
        .smp_stb (smp_stb),
        .sym_stb (sym_req),
        .dibit   (dibit),
        .impulse (impulse)
    );

    srrc_tx_flt flt_i (
        .clk       (clk),
        .reset     (reset),
        .smp_stb   (smp_stb),
        .in        (impulse.i),
        .out       (tx_i),
        .out_valid (tx_valid)
    );

    srrc_tx_flt flt_q (
        .clk       (clk),
        .reset     (reset),
        .smp_stb   (smp_stb),
        .in        (impulse.q),
        .out       (tx_q),
        .out_valid ()  // Same timing as flt_i.
    );

    assign tx = '{i: tx_i, q: tx_q};

endmodule

`default_nettype wire

//--- test/srrc_ref_model.svh
`ifndef SRRC_REF_MODEL_SVH
`define SRRC_REF_MODEL_SVH

// One rail of filter taps, element 0 is the newest sample x0.
typedef tx_sample_pkg::sample_t [srrc_coef_pkg::NUM_TAPS-1:0] tap_vec_t;

// Gray mapping. Bit 0 gives the sign of I, bit 1 the sign of Q.
function automatic tx_sample_pkg::iq_sample_t map_dibit(
    input logic [1:0] d,
    input int         amp
);
    tx_sample_pkg::iq_sample_t r;
    r.i = d[0] ? tx_sample_pkg::sample_t'(-amp) : tx_sample_pkg::sample_t'(amp);
    r.q = d[1] ? tx_sample_pkg::sample_t'(-amp) : tx_sample_pkg::sample_t'(amp);
    return r;
endfunction

// Bit-exact filter output for one set of taps.
function automatic tx_sample_pkg::sample_t srrc_eval(input tap_vec_t x);
    tx_sample_pkg::sample_t lo;
    tx_sample_pkg::sample_t hi;
    tx_sample_pkg::sample_t pre;
    tx_sample_pkg::sample_t slice;
    longint                 prod;
    int                     acc;
    acc = 0;
    for (int k = 0; k < srrc_coef_pkg::NUM_UNIQUE; k++) begin
        lo = x[k];
        hi = x[srrc_coef_pkg::NUM_TAPS-1-k];
        if (k == srrc_coef_pkg::NUM_UNIQUE - 1) begin
            pre = lo;  // Center tap has no mirror.
        end else begin
            pre = tx_sample_pkg::sample_t'(int'(lo) + int'(hi));
        end
        prod  = longint'(pre) * longint'(srrc_coef_pkg::COEF[k]);
        slice = tx_sample_pkg::sample_t'(prod >>> srrc_coef_pkg::PROD_LSB);
        acc   = acc + int'(slice);
    end
    // Sum modulo 2**18 is the same whatever the tree shape.
    return tx_sample_pkg::sample_t'(acc);
endfunction

`endif

//--- test/tb_qpsk_tx.sv
`timescale 1ns/1ps
`default_nettype none

module tb_qpsk_tx;

    `include "srrc_ref_model.svh"

    localparam int CLKS_PER_SAMPLE    = 4;
    localparam int SAMPLES_PER_SYMBOL = 4;
    localparam int AMPLITUDE          = 40000;
    localparam int RESET_CYCLES       = 5;
    localparam int RANDOM_SEED        = 45235;
    localparam int RANDOM_SYMBOLS     = 200;
    localparam int WAIT_LIMIT         = 4 * CLKS_PER_SAMPLE * SAMPLES_PER_SYMBOL;
    localparam int CENTER_IDX         = 1 + (srrc_coef_pkg::NUM_TAPS - 1) / 2;
    localparam logic [1:0] FOLLOW_UP [4] = '{2'b01, 2'b11, 2'b10, 2'b00};

    logic                      clk;
    logic                      reset;
    logic [1:0]                dibit;
    logic                      sym_req;
    tx_sample_pkg::iq_sample_t tx;
    logic                      tx_valid;

    tap_vec_t                  hist_i;
    tap_vec_t                  hist_q;
    tx_sample_pkg::iq_sample_t imp_now;   // Held by the mapper, x0 at the next strobe.
    tx_sample_pkg::iq_sample_t imp_next;  // Loaded at the latest sym_req.
    tx_sample_pkg::iq_sample_t captured [$];
    bit                        capture_on = 1'b0;
    bit                        timed_out  = 1'b0;
    int                        err_count  = 0;
    int                        n_checks   = 0;
    int                        n_tests    = 0;

    qpsk_tx_top #(
        .CLKS_PER_SAMPLE    (CLKS_PER_SAMPLE),
        .SAMPLES_PER_SYMBOL (SAMPLES_PER_SYMBOL),
        .AMPLITUDE          (AMPLITUDE)
    ) UUT (
        .clk      (clk),
        .reset    (reset),
        .dibit    (dibit),
        .sym_req  (sym_req),
        .tx       (tx),
        .tx_valid (tx_valid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Comparison against the model, sampled mid-cycle.
    initial begin
        tx_sample_pkg::sample_t exp_i;
        tx_sample_pkg::sample_t exp_q;
        forever begin
            @(negedge clk);
            if (reset) begin
                hist_i   = '0;
                hist_q   = '0;
                imp_now  = '0;
                imp_next = '0;
            end else begin
                if (tx_valid) begin
                    hist_i   = {hist_i[srrc_coef_pkg::NUM_TAPS-2:0], imp_now.i};
                    hist_q   = {hist_q[srrc_coef_pkg::NUM_TAPS-2:0], imp_now.q};
                    imp_now  = imp_next;
                    imp_next = '0;  // Zero-stuffing between symbols.
                    exp_i    = srrc_eval(hist_i);
                    exp_q    = srrc_eval(hist_q);
                    n_checks++;
                    assert (tx.i == exp_i) else begin
                        $display("Fail tx.i: expected 0x%05h, got 0x%05h", exp_i, tx.i);
                        err_count++;
                    end
                    assert (tx.q == exp_q) else begin
                        $display("Fail tx.q: expected 0x%05h, got 0x%05h", exp_q, tx.q);
                        err_count++;
                    end
                    if (capture_on) begin
                        captured.push_back(tx);
                    end
                end
                if (sym_req) begin
                    imp_next = map_dibit(dibit, AMPLITUDE);
                end
            end
        end
    end

    task automatic check_idle_outputs();
        assert (!tx_valid) else begin
            $display("Fail tx_valid: expected 0x0, got 0x%0h", tx_valid);
            err_count++;
        end
        assert (!sym_req) else begin
            $display("Fail sym_req: expected 0x0, got 0x%0h", sym_req);
            err_count++;
        end
        assert (tx == '0) else begin
            $display("Fail tx: expected 0x%09h, got 0x%09h", 36'h0, tx);
            err_count++;
        end
    endtask

    task automatic wait_strobe(input bit on_sym, output int cycles);
        cycles = 0;
        if (!timed_out) begin
            do begin
                @(negedge clk);
                cycles++;
            end while (!(on_sym ? sym_req : tx_valid) && cycles < WAIT_LIMIT);
            if (!(on_sym ? sym_req : tx_valid)) begin
                $display("Timeout: no %s within %0d cycles",
                         on_sym ? "sym_req" : "tx_valid", WAIT_LIMIT);
                timed_out = 1'b1;
                err_count++;
            end
        end
    endtask

    task automatic apply_reset(input bit check);
        reset <= 1'b1;
        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(posedge clk);
            if (c == RESET_CYCLES - 1) begin
                reset <= 1'b0;
            end
            if (check) begin
                @(negedge clk);
                check_idle_outputs();
            end
        end
        if (check) begin
            @(posedge clk);
        end
    endtask

    task automatic send_symbol(input logic [1:0] d);
        int cycles;
        dibit <= d;
        wait_strobe(1'b1, cycles);
        @(posedge clk);  // Edge that samples d.
    endtask

    task automatic wait_samples(input int n);
        int cycles;
        for (int k = 0; k < n; k++) begin
            wait_strobe(1'b0, cycles);
        end
        @(posedge clk);
    endtask

    task automatic report_test(input string name, input int errs_before);
        n_tests++;
        $display("Test %0d, %s: %s, %0d errors", n_tests, name,
                 (err_count == errs_before) ? "ok" : "failed", err_count - errs_before);
    endtask

    task automatic verify_reset_state();
        int errs_before;
        int cycles;
        errs_before = err_count;
        apply_reset(1'b1);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (!sym_req) begin
                check_idle_outputs();
            end
        end while (!sym_req && cycles < WAIT_LIMIT);
        if (!sym_req) begin
            $display("Timeout: no sym_req after reset");
            timed_out = 1'b1;
            err_count++;
        end
        wait_strobe(1'b0, cycles);
        assert (tx == '0) else begin
            $display("Fail tx: expected 0x%09h, got 0x%09h", 36'h0, tx);
            err_count++;
        end
        @(posedge clk);
        report_test("reset state", errs_before);
    endtask

    task automatic measure_strobe_spacing();
        int errs_before;
        int cycles;
        errs_before = err_count;
        wait_strobe(1'b0, cycles);
        for (int k = 0; k < 4; k++) begin
            wait_strobe(1'b0, cycles);
            assert (timed_out || cycles == CLKS_PER_SAMPLE) else begin
                $display("Fail tx_valid spacing: expected 0x%0h, got 0x%0h",
                         CLKS_PER_SAMPLE, cycles);
                err_count++;
            end
        end
        wait_strobe(1'b1, cycles);
        for (int k = 0; k < 3; k++) begin
            wait_strobe(1'b1, cycles);
            assert (timed_out || cycles == CLKS_PER_SAMPLE * SAMPLES_PER_SYMBOL) else begin
                $display("Fail sym_req spacing: expected 0x%0h, got 0x%0h",
                         CLKS_PER_SAMPLE * SAMPLES_PER_SYMBOL, cycles);
                err_count++;
            end
        end
        @(posedge clk);
        report_test("strobe spacing", errs_before);
    endtask

    task automatic run_impulse_response();
        int errs_before;
        errs_before = err_count;
        apply_reset(1'b0);
        send_symbol(2'b00);
        for (int k = 0; k < 4; k++) begin
            send_symbol(FOLLOW_UP[k]);
        end
        wait_samples(srrc_coef_pkg::NUM_TAPS + 1);
        report_test("impulse response", errs_before);
    endtask

    task automatic compare_quadrants();
        int                     errs_before;
        int                     diff;
        logic [1:0]             d;
        tx_sample_pkg::sample_t pk_i;
        tx_sample_pkg::sample_t pk_q;
        tx_sample_pkg::sample_t resp_00 [$];
        tx_sample_pkg::sample_t resp_11 [$];
        errs_before = err_count;
        for (int n = 0; n < 4; n++) begin
            d = 2'(n);
            apply_reset(1'b0);
            captured.delete();
            capture_on = 1'b1;
            dibit <= d;
            wait_samples(CENTER_IDX + SAMPLES_PER_SYMBOL);
            capture_on = 1'b0;
            if (captured.size() > CENTER_IDX) begin
                pk_i = captured[CENTER_IDX].i;  // First symbol on the center tap.
                pk_q = captured[CENTER_IDX].q;
                assert ((pk_i < 0) == d[0]) else begin
                    $display("Fail tx.i: dibit %b gives 0x%05h, wrong sign", d, pk_i);
                    err_count++;
                end
                assert ((pk_q < 0) == d[1]) else begin
                    $display("Fail tx.q: dibit %b gives 0x%05h, wrong sign", d, pk_q);
                    err_count++;
                end
                foreach (captured[k]) begin
                    if (d == 2'b00) resp_00.push_back(captured[k].i);
                    if (d == 2'b11) resp_11.push_back(captured[k].i);
                end
            end
        end
        for (int k = 0; k < resp_00.size() && k < resp_11.size(); k++) begin
            diff = int'(resp_00[k]) + int'(resp_11[k]);
            assert (diff <= srrc_coef_pkg::NUM_UNIQUE && diff >= -srrc_coef_pkg::NUM_UNIQUE)
            else begin
                $display("Fail tx.i: 0x%05h for 00 and 0x%05h for 11 are not negatives",
                         resp_00[k], resp_11[k]);
                err_count++;
            end
        end
        report_test("quadrant mapping", errs_before);
    endtask

    task automatic send_random_dibits();
        int         errs_before;
        logic [1:0] d;
        errs_before = err_count;
        for (int k = 0; k < RANDOM_SYMBOLS; k++) begin
            d = 2'($urandom % 4);
            send_symbol(d);
        end
        wait_samples(srrc_coef_pkg::NUM_TAPS + 1);
        report_test("random dibits", errs_before);
    endtask

    initial begin
        int unsigned seed_val;
        reset    = 1'b1;
        dibit    = 2'b00;
        seed_val = $urandom(RANDOM_SEED);
        apply_reset(1'b0);
        verify_reset_state();
        measure_strobe_spacing();
        run_impulse_response();
        compare_quadrants();
        send_random_dibits();
        $display("Tests: %0d, samples compared: %0d, errors: %0d", n_tests, n_checks, err_count);
        if (err_count == 0 && !timed_out && n_checks > 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+test
logic/tx_sample_pkg.sv
logic/srrc_coef_pkg.sv
logic/tx_rate_gen.sv
logic/qpsk_mapper.sv
logic/srrc_tx_flt.sv
logic/qpsk_tx_top.sv
test/tb_qpsk_tx.sv
